//--- tb.f
source/image_pkg.sv
source/frame_memory.sv
source/mem_arbiter.sv
source/wb_pixel_port.sv
source/pixel_streamer.sv
source/palette_map.sv
source/image_stream_top.sv
test/image_stream_asserts.sv
test/tb_image_stream.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_image_stream -f tb.f
	./obj_dir/Vtb_image_stream +verilator+error+limit+1000

clean:
	rm -rf obj_dir

//--- test/tb_image_stream.sv
module tb_image_stream;
    timeunit 1ns;
    timeprecision 100ps;
    import image_pkg::*;

    localparam int num_pixels = 64;
    localparam int max_cycles = 6000; // Three frames at 30 percent stall plus loads, with margin
    localparam int ack_limit  = 20;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [wb_adr_bits-1:0] wb_adr;
    logic [wb_dat_bits-1:0] wb_dat_w;
    logic [wb_dat_bits-1:0] wb_dat_r;
    logic                   wb_ack;
    logic                   out_valid;
    logic [rgb_bits-1:0]    out_data;
    logic                   out_sop;
    logic                   out_eop;
    logic                   out_ready;

    logic [colour_bits-1:0] mem_model [num_pixels]; // Frame as the host wrote it
    logic [rgb_bits-1:0]    pal_model [8];
    int                     exp_idx;                // Next pixel due on the stream
    int                     beat_count;
    int                     cycles = 0;
    logic [31:0]            main_state;
    logic [31:0]            sink_state;

    image_stream_top #(.num_pixels(num_pixels)) i_dut (
        .clk, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .out_valid, .out_data, .out_sop, .out_eop, .out_ready
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("Timeout: test still running after %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    // Protocol checker failures end the run at once
    always @(posedge clk) begin
        if (i_dut.i_asserts.error_count != 0) begin
            $display("Protocol assertion failed during the run");
            $display("RESULT: FAIL");
            $fatal(1, "Assertion failure");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // One classic cycle, released the cycle after ack as the slave drops it
    task automatic wb_access(input logic write, input logic [15:0] adr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge clk);
        #0.5;
        while (!wb_ack) begin
            if (waited == ack_limit) begin
                $display("Wishbone access to %0h got no ack within %0d cycles", adr, ack_limit);
                $display("RESULT: FAIL");
                $fatal(1, "Bus timeout");
            end
            waited++;
            @(posedge clk);
            #0.5;
        end
        rdata = wb_dat_r;
        @(posedge clk);
        #0.5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_pixel(input int idx, input logic [2:0] colour);
        logic [15:0] unused;
        mem_model[idx] = colour;
        wb_access(1'b1, 16'(idx), 16'(colour), unused);
    endtask

    task automatic write_palette(input int idx, input logic [11:0] rgb);
        logic [15:0] unused;
        pal_model[idx] = rgb;
        wb_access(1'b1, palette_base + 16'(idx), 16'(rgb), unused);
    endtask

    task automatic write_ctrl(input logic run_bit);
        logic [15:0] unused;
        wb_access(1'b1, ctrl_adr, 16'(run_bit), unused);
    endtask

    task automatic read_check(input logic [15:0] adr, input logic [31:0] expected,
                              input string name);
        logic [15:0] data;
        wb_access(1'b0, adr, '0, data);
        check_value($sformatf("%s@%0h", name, adr), expected, 32'(data));
    endtask

    // Returns on a drive point once the sink has taken target beats
    task automatic wait_beats(input int target);
        do begin
            @(posedge clk);
        end while (beat_count < target);
        #0.5;
    endtask

    // Stream sink, random out_ready about 70 percent high
    initial begin
        out_ready  = 1'b0;
        exp_idx    = 0;
        beat_count = 0;
        sink_state = ~32'd43;
        @(negedge reset);
        forever begin
            @(posedge clk);
            #0.5;
            sink_state = xorshift32(sink_state);
            out_ready  = (sink_state % 10) < 7;
            if (out_valid && out_ready) begin // Beat taken at the next edge
                check_value($sformatf("stream_data[%0d]", exp_idx),
                            pal_model[mem_model[exp_idx]], out_data);
                check_value("stream_sop", exp_idx == 0, out_sop);
                check_value("stream_eop", exp_idx == num_pixels - 1, out_eop);
                exp_idx = (exp_idx + 1) % num_pixels;
                beat_count++;
            end
        end
    end

    initial begin
        int base;
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        main_state = 32'd43;
        for (int i = 0; i < 8; i++) begin
            pal_model[i] = {{4{i[2]}}, {4{i[1]}}, {4{i[0]}}}; // Primary and mixed colours
        end
        repeat (4) @(posedge clk);
        #0.5;
        reset = 1'b0;

        // Stopped stream stays silent, palette at reset colours
        repeat (20) begin
            @(posedge clk);
            #0.5;
            check_value("idle_valid", 0, 32'(out_valid));
        end
        for (int i = 0; i < 8; i++) read_check(palette_base + 16'(i), pal_model[i], "reset_pal");

        // Load the frame and read it back
        for (int i = 0; i < num_pixels; i++) begin
            main_state = xorshift32(main_state);
            write_pixel(i, main_state[2:0]);
        end
        for (int i = 0; i < num_pixels; i++) read_check(16'(i), mem_model[i], "pixel_readback");

        // New palette, then two frames
        for (int i = 0; i < 8; i++) begin
            main_state = xorshift32(main_state);
            write_palette(i, main_state[11:0]);
        end
        write_ctrl(1'b1);
        wait_beats(2 * num_pixels);

        // Host reads compete with the streamer for the RAM
        repeat (24) begin
            main_state = xorshift32(main_state);
            if (main_state[8]) begin
                read_check(palette_base + 16'(main_state[2:0]), pal_model[main_state[2:0]],
                           "live_pal");
            end else begin
                read_check(16'(main_state[5:0]), mem_model[main_state[5:0]], "live_pixel");
            end
        end
        base = (beat_count / num_pixels + 1) * num_pixels;
        wait_beats(base);

        // Stop 20 pixels into a frame, patch some pixels, restart at pixel 0
        wait_beats(base + 20);
        write_ctrl(1'b0);
        exp_idx = 0;
        read_check(ctrl_adr, 0, "run_cleared");
        repeat (8) begin
            main_state = xorshift32(main_state);
            write_pixel(int'(main_state[5:0]), main_state[10:8]);
        end
        base = beat_count;
        write_ctrl(1'b1);
        wait_beats(base + num_pixels);

        if (i_dut.i_asserts.error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Protocol assertions failed %0d times", i_dut.i_asserts.error_count);
            $display("RESULT: FAIL");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

//--- test/image_stream_asserts.sv
module image_stream_asserts (
    input logic                           clk,
    input logic                           reset,
    input logic                           wb_stb,
    input logic                           wb_ack,
    input logic                           out_valid,
    input logic                           out_ready,
    input logic [image_pkg::rgb_bits-1:0] out_data,
    input logic                           out_sop,
    input logic                           out_eop
);
    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0; // Failed assertions so far

    // No beat in reset or in the first cycle after it
    assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            error_count++;
            $error("out_valid high during or right after reset");
        end

    // Stalled beat holds its payload
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_sop) && $stable(out_eop))
        else begin
            error_count++;
            $error("Output beat changed while stalled");
        end

    assert property (@(posedge clk) disable iff (reset) wb_ack |-> wb_stb)
        else begin
            error_count++;
            $error("wb_ack high without wb_stb");
        end

    // A frame is longer than one pixel
    assert property (@(posedge clk) disable iff (reset) out_valid |-> !(out_sop && out_eop))
        else begin
            error_count++;
            $error("out_sop and out_eop high together");
        end

endmodule

bind image_stream_top image_stream_asserts i_asserts (
    .clk(clk), .reset(reset), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
    .out_sop(out_sop), .out_eop(out_eop)
);

//--- source/image_stream_top.sv
module image_stream_top #(
    parameter int num_pixels = 640*480
) (
    input  logic                              clk,
    input  logic                              reset,
    // Wishbone host
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [image_pkg::wb_adr_bits-1:0] wb_adr,
    input  logic [image_pkg::wb_dat_bits-1:0] wb_dat_w,
    output logic [image_pkg::wb_dat_bits-1:0] wb_dat_r,
    output logic                              wb_ack,
    // RGB pixel stream
    output logic                              out_valid,
    output logic [image_pkg::rgb_bits-1:0]    out_data,
    output logic                              out_sop,
    output logic                              out_eop,
    input  logic                              out_ready
);
    import image_pkg::*;

    localparam int adr_bits = $clog2(num_pixels);

    // Host requester
    logic                   host_req;
    logic                   host_we;
    logic [adr_bits-1:0]    host_adr;
    logic [colour_bits-1:0] host_wdata;
    logic                   host_gnt;
    logic                   host_rvalid;

    // Streamer requester
    logic                   strm_req;
    logic [adr_bits-1:0]    strm_adr;
    logic                   strm_gnt;
    logic                   strm_rvalid;

    // RAM port
    logic                   mem_en;
    logic                   mem_we;
    logic [adr_bits-1:0]    mem_adr;
    logic [colour_bits-1:0] mem_wdata;
    logic [colour_bits-1:0] mem_rdata;
    logic [colour_bits-1:0] rdata;      // Shared read data

    // Control and palette
    logic                   run;
    logic                   pal_we;
    logic [colour_bits-1:0] pal_idx;
    logic [rgb_bits-1:0]    pal_wdata;
    logic [rgb_bits-1:0]    pal_rdata;

    // Index stream
    logic                   col_valid;
    logic                   col_ready;
    logic [colour_bits-1:0] col_index;
    logic                   col_sop;
    logic                   col_eop;

    wb_pixel_port #(.num_pixels(num_pixels)) i_wb_pixel_port (
        .clk, .reset,
        .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr), .dat_w(wb_dat_w),
        .dat_r(wb_dat_r), .ack(wb_ack),
        .host_req, .host_we, .host_adr, .host_wdata,
        .host_gnt, .host_rvalid, .rdata,
        .run, .pal_we, .pal_idx, .pal_wdata, .pal_rdata
    );

    pixel_streamer #(.num_pixels(num_pixels)) i_pixel_streamer (
        .clk, .reset, .run,
        .strm_req, .strm_adr, .strm_gnt, .strm_rvalid, .rdata,
        .col_valid, .col_index, .col_sop, .col_eop, .col_ready
    );

    mem_arbiter #(.num_pixels(num_pixels)) i_mem_arbiter (
        .clk, .reset,
        .host_req, .host_we, .host_adr, .host_wdata, .host_gnt, .host_rvalid,
        .strm_req, .strm_adr, .strm_gnt, .strm_rvalid,
        .mem_en, .mem_we, .mem_adr, .mem_wdata, .mem_rdata, .rdata
    );

    frame_memory #(.num_pixels(num_pixels)) i_frame_memory (
        .clk, .en(mem_en), .we(mem_we), .adr(mem_adr), .wdata(mem_wdata), .rdata(mem_rdata)
    );

    palette_map i_palette_map (
        .clk, .reset, .run,
        .col_valid, .col_index, .col_sop, .col_eop, .col_ready,
        .pal_we, .pal_idx, .pal_wdata, .pal_rdata,
        .out_valid, .out_data, .out_sop, .out_eop, .out_ready
    );

endmodule

//--- source/palette_map.sv
module palette_map (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              run,
    // Colour index stream in
    input  logic                              col_valid,
    input  logic [image_pkg::colour_bits-1:0] col_index,
    input  logic                              col_sop,
    input  logic                              col_eop,
    output logic                              col_ready,
    // Host access to the palette
    input  logic                              pal_we,
    input  logic [image_pkg::colour_bits-1:0] pal_idx,
    input  logic [image_pkg::rgb_bits-1:0]    pal_wdata,
    output logic [image_pkg::rgb_bits-1:0]    pal_rdata,
    // RGB stream out
    output logic                              out_valid,
    output logic [image_pkg::rgb_bits-1:0]    out_data,
    output logic                              out_sop,
    output logic                              out_eop,
    input  logic                              out_ready
);
    import image_pkg::*;

    localparam int num_entries = 2**colour_bits;

    logic [rgb_bits-1:0] pal [num_entries];

    assign pal_rdata = pal[pal_idx];
    assign col_ready = !out_valid || out_ready; // Empty or draining this cycle

    // Palette, back to the default colours on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_entries; i++) begin
                pal[i] <= default_palette(colour_bits'(i));
            end
        end else if (pal_we) begin
            pal[pal_idx] <= pal_wdata;
        end
    end

    // Output register stage
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            out_valid <= 1'b0;      // Held beat dropped when stopped
        end else if (col_ready) begin
            out_valid <= col_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (col_valid && col_ready) begin
            out_data <= pal[col_index]; // Look up colour
            out_sop  <= col_sop;
            out_eop  <= col_eop;
        end
    end

endmodule

//--- source/pixel_streamer.sv
module pixel_streamer #(
    parameter int num_pixels = 640*480
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              run,
    // Read requests to the arbiter
    output logic                              strm_req,
    output logic [$clog2(num_pixels)-1:0]     strm_adr,
    input  logic                              strm_gnt,
    input  logic                              strm_rvalid,
    input  logic [image_pkg::colour_bits-1:0] rdata,
    // Colour index stream
    output logic                              col_valid,
    output logic [image_pkg::colour_bits-1:0] col_index,
    output logic                              col_sop,
    output logic                              col_eop,
    input  logic                              col_ready
);
    import image_pkg::*;

    localparam int adr_bits = $clog2(num_pixels);
    localparam int depth    = 4;                  // Prefetch queue entries
    localparam int ptr_bits = $clog2(depth);
    localparam int cnt_bits = $clog2(depth) + 1;

    logic [adr_bits-1:0] req_idx;    // Next pixel to request
    logic [cnt_bits-1:0] used;       // Reads in flight plus queued entries
    logic [cnt_bits-1:0] count;      // Queued entries
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic                tag_sop;    // Tags of the read in flight
    logic                tag_eop;
    logic                push;
    logic                pop;

    // Queue storage
    logic [colour_bits-1:0] q_col [depth];
    logic                   q_sop [depth];
    logic                   q_eop [depth];

    // Only ask while a slot is guaranteed for the answer
    assign strm_req = run && (used < cnt_bits'(depth));
    assign strm_adr = req_idx;

    assign push = run && strm_rvalid; // Late data after run drops is discarded
    assign pop  = col_valid && col_ready;

    // Head of queue
    assign col_valid = (count != '0);
    assign col_index = q_col[rd_ptr];
    assign col_sop   = q_sop[rd_ptr];
    assign col_eop   = q_eop[rd_ptr];

    // Request index, wraps to 0 after the last pixel
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            req_idx <= '0;  // Frame restarts at pixel 0
        end else if (strm_gnt) begin
            req_idx <= (req_idx == adr_bits'(num_pixels - 1)) ? '0 : req_idx + 1'b1;
        end
    end

    // Tags follow the read, memory answers exactly one cycle later
    always_ff @(posedge clk) begin
        if (strm_gnt) begin
            tag_sop <= (req_idx == '0);
            tag_eop <= (req_idx == adr_bits'(num_pixels - 1));
        end
    end

    // Credit and occupancy counters
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            used   <= '0;
            count  <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            used  <= used + cnt_bits'(strm_gnt) - cnt_bits'(pop);
            count <= count + cnt_bits'(push) - cnt_bits'(pop);
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Queue write
    always_ff @(posedge clk) begin
        if (push) begin
            q_col[wr_ptr] <= rdata;
            q_sop[wr_ptr] <= tag_sop;
            q_eop[wr_ptr] <= tag_eop;
        end
    end

endmodule

//--- source/wb_pixel_port.sv
module wb_pixel_port #(
    parameter int num_pixels = 640*480
) (
    input  logic                              clk,
    input  logic                              reset,
    // Wishbone classic slave
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [image_pkg::wb_adr_bits-1:0] adr,
    input  logic [image_pkg::wb_dat_bits-1:0] dat_w,
    output logic [image_pkg::wb_dat_bits-1:0] dat_r,
    output logic                              ack,
    // Frame memory request through the arbiter
    output logic                              host_req,
    output logic                              host_we,
    output logic [$clog2(num_pixels)-1:0]     host_adr,
    output logic [image_pkg::colour_bits-1:0] host_wdata,
    input  logic                              host_gnt,
    input  logic                              host_rvalid,
    input  logic [image_pkg::colour_bits-1:0] rdata,
    // Control and palette
    output logic                              run,
    output logic                              pal_we,
    output logic [image_pkg::colour_bits-1:0] pal_idx,
    output logic [image_pkg::rgb_bits-1:0]    pal_wdata,
    input  logic [image_pkg::rgb_bits-1:0]    pal_rdata
);
    import image_pkg::*;

    localparam int adr_bits    = $clog2(num_pixels);
    localparam int num_entries = 2**colour_bits;

    logic is_pal;
    logic is_ctrl;
    logic is_pix;
    logic new_xfer;                 // Transfer seen and not yet served
    logic pix_wait;                 // Pixel read granted, data due next cycle
    logic [wb_dat_bits-1:0] reg_rdata;

    // Address decode, registers take precedence over the pixel range
    assign is_pal  = (adr >= palette_base) && (adr < palette_base + num_entries);
    assign is_ctrl = (adr == ctrl_adr);
    assign is_pix  = !is_pal && !is_ctrl && (adr < num_pixels);

    // Ack low gives the one idle cycle between transfers
    assign new_xfer = cyc && stb && !ack && !pix_wait;

    // Pixel access held on the arbiter until granted
    assign host_req   = new_xfer && is_pix;
    assign host_we    = we;
    assign host_adr   = adr_bits'(adr);
    assign host_wdata = dat_w[colour_bits-1:0];

    // Palette write strobe, lands in the same edge as the ack
    assign pal_we    = new_xfer && we && is_pal;
    assign pal_idx   = adr[colour_bits-1:0];
    assign pal_wdata = dat_w[rgb_bits-1:0];

    always_comb begin
        if (is_pal) begin
            reg_rdata = wb_dat_bits'(pal_rdata);
        end else if (is_ctrl) begin
            reg_rdata = wb_dat_bits'(run);
        end else begin
            reg_rdata = '0; // Unmapped reads as zero
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack      <= 1'b0;
            pix_wait <= 1'b0;
            run      <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (new_xfer && !is_pix) begin
                ack <= 1'b1;            // Register or unmapped, one cycle
            end
            if (host_gnt && host_we) begin
                ack <= 1'b1;            // Write done at the grant
            end
            if (host_gnt && !host_we) begin
                pix_wait <= 1'b1;
            end
            if (host_rvalid) begin
                pix_wait <= 1'b0;
                ack      <= cyc && stb; // Master may have given up
            end
            if (new_xfer && we && is_ctrl) begin
                run <= dat_w[0];
            end
        end
    end

    // Read data register
    always_ff @(posedge clk) begin
        if (new_xfer && !is_pix) begin
            dat_r <= reg_rdata;
        end else if (host_rvalid) begin
            dat_r <= wb_dat_bits'(rdata);
        end
    end

endmodule

//--- source/mem_arbiter.sv
module mem_arbiter #(
    parameter int num_pixels = 640*480
) (
    input  logic                              clk,
    input  logic                              reset,
    // Host port requester
    input  logic                              host_req,
    input  logic                              host_we,
    input  logic [$clog2(num_pixels)-1:0]     host_adr,
    input  logic [image_pkg::colour_bits-1:0] host_wdata,
    output logic                              host_gnt,
    output logic                              host_rvalid,
    // Streamer requester, reads only
    input  logic                              strm_req,
    input  logic [$clog2(num_pixels)-1:0]     strm_adr,
    output logic                              strm_gnt,
    output logic                              strm_rvalid,
    // Frame memory side
    output logic                              mem_en,
    output logic                              mem_we,
    output logic [$clog2(num_pixels)-1:0]     mem_adr,
    output logic [image_pkg::colour_bits-1:0] mem_wdata,
    input  logic [image_pkg::colour_bits-1:0] mem_rdata,
    output logic [image_pkg::colour_bits-1:0] rdata
);

    logic last_host; // High when the host had the last grant

    // Host wins unless the streamer is also asking and the host went last
    assign host_gnt = host_req && (!strm_req || !last_host);
    assign strm_gnt = strm_req && !host_gnt;

    // Steer the granted requester onto the RAM
    assign mem_en    = host_gnt || strm_gnt;
    assign mem_we    = host_gnt && host_we;           // Streamer never writes
    assign mem_adr   = host_gnt ? host_adr : strm_adr;
    assign mem_wdata = host_wdata;

    // Shared read bus, the rvalid pulse says whose data it is
    assign rdata = mem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_host   <= 1'b0;
            host_rvalid <= 1'b0;
            strm_rvalid <= 1'b0;
        end else begin
            if (mem_en) begin
                last_host <= host_gnt; // Priority flips after every grant
            end
            // One-cycle record of who read
            host_rvalid <= host_gnt && !host_we;
            strm_rvalid <= strm_gnt;
        end
    end

endmodule

//--- source/frame_memory.sv
module frame_memory #(
    parameter int num_pixels = 640*480
) (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            we,
    input  logic [$clog2(num_pixels)-1:0]   adr,
    input  logic [image_pkg::colour_bits-1:0] wdata,
    output logic [image_pkg::colour_bits-1:0] rdata
);
    import image_pkg::*;

    // One colour index per pixel
    logic [colour_bits-1:0] mem [num_pixels];

    // Registered read so the RAM maps onto block memory
    // A write returns the old contents on rdata
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[adr] <= wdata;  // Store new index
            end
            rdata <= mem[adr];      // Read before write
        end
    end

endmodule

//--- source/image_pkg.sv
package image_pkg;

    // Pixel and colour widths
    localparam int colour_bits = 3;  // Stored colour index
    localparam int rgb_bits    = 12; // 4 bits each of red, green, blue

    // Wishbone host bus
    localparam int wb_adr_bits = 16; // Word address
    localparam int wb_dat_bits = 16;

    // Register map, word addresses
    localparam logic [wb_adr_bits-1:0] palette_base = 16'h1000; // Eight entries follow
    localparam logic [wb_adr_bits-1:0] ctrl_adr     = 16'h1010; // Bit 0 is run

    // Palette after reset
    // Index bit 2 gives full red, bit 1 full green, bit 0 full blue
    function automatic logic [rgb_bits-1:0] default_palette(
        input logic [colour_bits-1:0] idx
    );
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
        red   = {4{idx[2]}};
        green = {4{idx[1]}};
        blue  = {4{idx[0]}};
        return {red, green, blue}; // Red in the top nibble
    endfunction

endpackage
